// File: src/host_dma_pkg.sv
package host_dma_pkg;

	// ----------------------------------------------------------
	// data path widths
	// ----------------------------------------------------------

	typedef logic [31:0] word_t;		// one pipe / memory word
	typedef logic [15:0] addr_t;		// word address, low bits used by memory
	typedef logic [15:0] count_t;		// fifo occupancy and transfer length

	typedef enum logic {
		DIR_WRITE = 1'b0,				// in fifo -> memory
		DIR_READ  = 1'b1				// memory -> out fifo
	} dir_e;

	// host transfer descriptor
	typedef struct packed {
		dir_e   dir;
		addr_t  start_addr;
		count_t word_count;				// must be nonzero
	} xfer_t;

	// burst command, same shape as the controller command port
	typedef struct packed {
		logic       is_read;
		addr_t      addr;
		logic [5:0] burst_len;			// words in this burst
	} mem_cmd_t;

	typedef enum logic [2:0] {
		IDLE,
		WR_WAIT,						// wait for a burst worth of input
		WR_BURST,
		RD_WAIT,						// wait for room in the out fifo
		RD_CMD,
		RD_BURST,
		DONE
	} dma_state_e;

endpackage

// File: src/block_fifo.sv
`timescale 1ns/1ps

module block_fifo #(
	parameter int FIFO_DEPTH = 1024,	// power of two
	parameter int BLOCK_SIZE = 128,
	parameter int HEADROOM   = 20
) (
	input  logic                 okClk,
	input  logic                 rst_n,
	input  logic                 push,
	input  host_dma_pkg::word_t  push_data,
	input  logic                 pop,
	output host_dma_pkg::word_t  pop_data,
	output logic                 empty,
	output host_dma_pkg::count_t count,
	output logic                 has_room,
	output logic                 has_block
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	// throttle thresholds in count units
	localparam host_dma_pkg::count_t ROOM_LIMIT =
		host_dma_pkg::count_t'(FIFO_DEPTH - HEADROOM - BLOCK_SIZE);
	localparam host_dma_pkg::count_t BLOCK_LIMIT = host_dma_pkg::count_t'(BLOCK_SIZE);
	localparam host_dma_pkg::count_t DEPTH_CNT   = host_dma_pkg::count_t'(FIFO_DEPTH);

	host_dma_pkg::word_t  mem [FIFO_DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	host_dma_pkg::count_t count_next;

	// ----------------------------------------------------------
	// storage
	// ----------------------------------------------------------

	always_ff @(posedge okClk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	assign pop_data = mem[rd_ptr];		// head word visible while not empty
	assign empty    = (count == '0);

	// ----------------------------------------------------------
	// occupancy and block flags
	// ----------------------------------------------------------

	always_comb begin
		count_next = count;
		if (push && !pop) begin
			count_next = count + host_dma_pkg::count_t'(1);
		end else if (pop && !push) begin
			count_next = count - host_dma_pkg::count_t'(1);
		end
	end

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			has_room  <= 1'b1;			// empty fifo always has room
			has_block <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + PTR_W'(1);	// wraps at the power-of-two depth
			end
			if (pop) begin
				rd_ptr <= rd_ptr + PTR_W'(1);
			end
			count     <= count_next;
			// flags follow the count after this edge
			has_room  <= (count_next <= ROOM_LIMIT);
			has_block <= (count_next >= BLOCK_LIMIT);
		end
	end

	// ----------------------------------------------------------
	// checks on the producer and the consumer
	// ----------------------------------------------------------

	a_no_push_full: assert property (@(posedge okClk) disable iff (!rst_n)
		push |-> (count != DEPTH_CNT))
		else $error("block_fifo: push while full");

	a_no_pop_empty: assert property (@(posedge okClk) disable iff (!rst_n)
		pop |-> !empty)
		else $error("block_fifo: pop while empty");

endmodule

// File: src/burst_mem.sv
`timescale 1ns/1ps

module burst_mem #(
	parameter int MEM_WORDS = 4096
) (
	input  logic                   okClk,
	input  logic                   rst_n,
	input  logic                   cmd_valid,
	input  host_dma_pkg::mem_cmd_t cmd,
	input  logic                   wr_valid,
	input  host_dma_pkg::word_t    wr_data,
	output logic                   cmd_ready,
	output logic                   rd_valid,
	output host_dma_pkg::word_t    rd_data
);

	localparam int AW = $clog2(MEM_WORDS);

	host_dma_pkg::word_t mem [MEM_WORDS];

	logic          busy;				// a burst is in progress
	logic          is_rd;
	logic [AW-1:0] ptr;					// address of the next word
	logic [5:0]    remain;				// words left in the burst
	logic          cmd_fire;
	logic          beat;

	assign cmd_ready = !busy;
	assign cmd_fire  = cmd_valid && cmd_ready;
	assign beat      = busy && (is_rd || wr_valid);	// reads stream every cycle

	assign rd_valid = busy && is_rd;
	assign rd_data  = mem[ptr];

	always_ff @(posedge okClk) begin
		if (busy && !is_rd && wr_valid) begin
			mem[ptr] <= wr_data;
		end
	end

	// ----------------------------------------------------------
	// burst sequencing
	// ----------------------------------------------------------

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			busy   <= 1'b0;
			is_rd  <= 1'b0;
			ptr    <= '0;
			remain <= '0;
		end else if (cmd_fire) begin
			busy   <= (cmd.burst_len != '0);
			is_rd  <= cmd.is_read;
			ptr    <= cmd.addr[AW-1:0];
			remain <= cmd.burst_len;
		end else if (beat) begin
			ptr    <= ptr + AW'(1);
			remain <= remain - 6'd1;
			if (remain == 6'd1) begin
				busy <= 1'b0;			// last word of the burst
			end
		end
	end

	a_wr_in_burst: assert property (@(posedge okClk) disable iff (!rst_n)
		wr_valid |-> (busy && !is_rd))
		else $error("burst_mem: write data outside a write burst");

	a_burst_in_range: assert property (@(posedge okClk) disable iff (!rst_n)
		cmd_fire |-> (int'(cmd.addr) + int'(cmd.burst_len) <= MEM_WORDS))
		else $error("burst_mem: burst runs past the end of memory");

endmodule

// File: src/burst_dma.sv
`timescale 1ns/1ps

module burst_dma #(
	parameter int FIFO_DEPTH = 1024,
	parameter int BURST_LEN  = 32		// at most 63
) (
	input  logic                   okClk,
	input  logic                   rst_n,

	// transfer descriptor
	input  logic                   xfer_valid,
	input  host_dma_pkg::xfer_t    xfer,
	output logic                   xfer_ready,
	output logic                   xfer_done,

	// input fifo side
	input  logic                   in_empty,
	input  host_dma_pkg::count_t   in_count,
	input  host_dma_pkg::word_t    in_data,
	output logic                   in_pop,

	// output fifo side
	input  host_dma_pkg::count_t   out_count,
	output logic                   out_push,
	output host_dma_pkg::word_t    out_data,

	// memory command and data
	input  logic                   cmd_ready,
	output logic                   cmd_valid,
	output host_dma_pkg::mem_cmd_t cmd,
	output logic                   wr_valid,
	output host_dma_pkg::word_t    wr_data,
	input  logic                   rd_valid,
	input  host_dma_pkg::word_t    rd_data
);

	localparam host_dma_pkg::count_t BURST_CNT = host_dma_pkg::count_t'(BURST_LEN);
	localparam host_dma_pkg::count_t DEPTH_CNT = host_dma_pkg::count_t'(FIFO_DEPTH);

	host_dma_pkg::dma_state_e state;
	host_dma_pkg::addr_t      cur_addr;	// address of the next burst
	host_dma_pkg::count_t     remain;	// words not yet commanded
	logic [5:0]               beats;	// words left in the current burst
	logic [5:0]               blen;
	host_dma_pkg::count_t     out_free;
	logic                     in_has_burst;
	logic                     cmd_fire;

	// ----------------------------------------------------------
	// burst sizing and flow conditions
	// ----------------------------------------------------------

	always_comb begin
		if (remain < BURST_CNT) begin
			blen = remain[5:0];			// short tail burst
		end else begin
			blen = 6'(BURST_LEN);
		end
	end

	assign out_free     = DEPTH_CNT - out_count;
	assign in_has_burst = (in_count >= host_dma_pkg::count_t'(blen));
	assign cmd_fire     = cmd_valid && cmd_ready;

	// ----------------------------------------------------------
	// outputs
	// ----------------------------------------------------------

	assign xfer_ready = (state == host_dma_pkg::IDLE);
	assign xfer_done  = (state == host_dma_pkg::DONE);

	assign cmd_valid = ((state == host_dma_pkg::WR_WAIT) && (remain != '0) && in_has_burst)
		|| (state == host_dma_pkg::RD_CMD);

	assign cmd = '{
		is_read:   (state == host_dma_pkg::RD_CMD),
		addr:      cur_addr,
		burst_len: blen
	};

	assign wr_valid = (state == host_dma_pkg::WR_BURST) && !in_empty;
	assign in_pop   = wr_valid;			// one input word per memory write
	assign wr_data  = in_data;

	assign out_push = (state == host_dma_pkg::RD_BURST) && rd_valid;
	assign out_data = rd_data;

	// ----------------------------------------------------------
	// transfer FSM
	// ----------------------------------------------------------

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= host_dma_pkg::IDLE;
			cur_addr <= '0;
			remain   <= '0;
			beats    <= '0;
		end else begin
			// every accepted command retires one burst of the descriptor
			if (cmd_fire) begin
				cur_addr <= cur_addr + host_dma_pkg::addr_t'(blen);
				remain   <= remain - host_dma_pkg::count_t'(blen);
				beats    <= blen;
			end

			case (state)
				host_dma_pkg::IDLE: begin
					if (xfer_valid) begin
						cur_addr <= xfer.start_addr;
						remain   <= xfer.word_count;
						if (xfer.dir == host_dma_pkg::DIR_WRITE) begin
							state <= host_dma_pkg::WR_WAIT;
						end else begin
							state <= host_dma_pkg::RD_WAIT;
						end
					end
				end

				host_dma_pkg::WR_WAIT: begin
					if (remain == '0) begin
						state <= host_dma_pkg::DONE;
					end else if (cmd_fire) begin
						state <= host_dma_pkg::WR_BURST;
					end
				end

				host_dma_pkg::WR_BURST: begin
					if (wr_valid) begin
						beats <= beats - 6'd1;
						if (beats == 6'd1) begin
							state <= host_dma_pkg::WR_WAIT;
						end
					end
				end

				host_dma_pkg::RD_WAIT: begin
					if (remain == '0) begin
						state <= host_dma_pkg::DONE;
					end else if (out_free >= host_dma_pkg::count_t'(blen)) begin
						state <= host_dma_pkg::RD_CMD;	// room for the whole burst
					end
				end

				host_dma_pkg::RD_CMD: begin
					if (cmd_fire) begin
						state <= host_dma_pkg::RD_BURST;
					end
				end

				host_dma_pkg::RD_BURST: begin
					if (rd_valid) begin
						beats <= beats - 6'd1;
						if (beats == 6'd1) begin
							state <= host_dma_pkg::RD_WAIT;
						end
					end
				end

				host_dma_pkg::DONE: begin
					state <= host_dma_pkg::IDLE;
				end

				default: begin
					state <= host_dma_pkg::IDLE;
				end
			endcase
		end
	end

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------

	a_nonzero_xfer: assert property (@(posedge okClk) disable iff (!rst_n)
		(xfer_valid && xfer_ready) |-> (xfer.word_count != '0))
		else $error("burst_dma: descriptor with zero word count");

	// memory must only return data for a read burst that is waiting for it
	a_rd_expected: assert property (@(posedge okClk) disable iff (!rst_n)
		rd_valid |-> (state == host_dma_pkg::RD_BURST))
		else $error("burst_dma: read data outside a read burst");

endmodule

// File: src/host_dma_top.sv
`timescale 1ns/1ps

module host_dma_top #(
	parameter int FIFO_DEPTH = 1024,
	parameter int BLOCK_SIZE = 128,		// words per host block
	parameter int HEADROOM   = 20,
	parameter int BURST_LEN  = 32,
	parameter int MEM_WORDS  = 4096
) (
	input  logic                okClk,
	input  logic                rst_n,

	// host pipe in
	input  logic                in_valid,
	input  host_dma_pkg::word_t in_data,
	output logic                in_ready,

	// host pipe out
	input  logic                out_ready,
	output logic                out_valid,
	output host_dma_pkg::word_t out_data,
	output logic                out_block_ready,

	// transfer control
	input  logic                xfer_valid,
	input  host_dma_pkg::xfer_t xfer,
	output logic                xfer_ready,
	output logic                xfer_done
);

	logic                   in_empty;
	logic                   in_pop;
	host_dma_pkg::count_t   in_count;
	host_dma_pkg::word_t    in_word;
	logic                   out_empty;
	logic                   out_push;
	host_dma_pkg::count_t   out_count;
	host_dma_pkg::word_t    out_word;
	logic                   cmd_valid;
	logic                   cmd_ready;
	host_dma_pkg::mem_cmd_t cmd;
	logic                   wr_valid;
	host_dma_pkg::word_t    wr_data;
	logic                   rd_valid;
	host_dma_pkg::word_t    rd_data;

	assign out_valid = !out_empty;

	// ----------------------------------------------------------
	// pipe fifos
	// ----------------------------------------------------------

	block_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.BLOCK_SIZE (BLOCK_SIZE),
		.HEADROOM   (HEADROOM)
	) in_fifo (
		.okClk     (okClk),
		.rst_n     (rst_n),
		.push      (in_valid && in_ready),	// host handshake
		.push_data (in_data),
		.pop       (in_pop),
		.pop_data  (in_word),
		.empty     (in_empty),
		.count     (in_count),
		.has_room  (in_ready),				// block throttle
		.has_block ()
	);

	block_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.BLOCK_SIZE (BLOCK_SIZE),
		.HEADROOM   (HEADROOM)
	) out_fifo (
		.okClk     (okClk),
		.rst_n     (rst_n),
		.push      (out_push),
		.push_data (out_word),
		.pop       (out_valid && out_ready),
		.pop_data  (out_data),
		.empty     (out_empty),
		.count     (out_count),
		.has_room  (),
		.has_block (out_block_ready)		// a whole block ready for the host
	);

	// ----------------------------------------------------------
	// dma engine and burst memory
	// ----------------------------------------------------------

	burst_dma #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.BURST_LEN  (BURST_LEN)
	) dma (
		.okClk      (okClk),
		.rst_n      (rst_n),
		.xfer_valid (xfer_valid),
		.xfer       (xfer),
		.xfer_ready (xfer_ready),
		.xfer_done  (xfer_done),
		.in_empty   (in_empty),
		.in_count   (in_count),
		.in_data    (in_word),
		.in_pop     (in_pop),
		.out_count  (out_count),
		.out_push   (out_push),
		.out_data   (out_word),
		.cmd_ready  (cmd_ready),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.wr_valid   (wr_valid),
		.wr_data    (wr_data),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data)
	);

	burst_mem #(
		.MEM_WORDS (MEM_WORDS)
	) mem (
		.okClk     (okClk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.wr_valid  (wr_valid),
		.wr_data   (wr_data),
		.cmd_ready (cmd_ready),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data)
	);

endmodule

// File: verif/host_dma_checks.svh
`ifndef HOST_DMA_CHECKS_SVH
`define HOST_DMA_CHECKS_SVH

	// 32-bit xorshift step, the source of all write data
	function automatic host_dma_pkg::word_t xorshift32(input host_dma_pkg::word_t x);
		host_dma_pkg::word_t y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ----------------------------------------------------------
	// compare tasks, one per result type
	// ----------------------------------------------------------

	task automatic check_word(input string name, input host_dma_pkg::word_t exp,
		input host_dma_pkg::word_t act);
		if (exp !== act) begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			$display("STATUS: FAIL");
			$fatal(1, "data word mismatch on %s", name);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
			$display("STATUS: FAIL");
			$fatal(1, "flag mismatch on %s", name);
		end
	endtask

	task automatic check_count(input string name, input host_dma_pkg::count_t exp,
		input host_dma_pkg::count_t act);
		if (exp !== act) begin
			$display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
			$display("STATUS: FAIL");
			$fatal(1, "count mismatch on %s", name);
		end
	endtask

`endif

// File: verif/host_dma_tb.sv
`timescale 1ns/1ps

module host_dma_tb;

	localparam int FIFO_DEPTH = 64;
	localparam int BLOCK_SIZE = 16;
	localparam int HEADROOM   = 4;
	localparam int BURST_LEN  = 8;
	localparam int MEM_WORDS  = 256;
	localparam int NUM_ROWS   = 10;

	// words accepted by a full input fifo before the throttle closes
	localparam host_dma_pkg::count_t FILL_WORDS =
		host_dma_pkg::count_t'(FIFO_DEPTH - HEADROOM - BLOCK_SIZE + 1);

	localparam logic [1:0] MODE_STREAM = 2'd0;	// host side runs with the transfer
	localparam logic [1:0] MODE_FILL   = 2'd1;	// fill input fifo until throttled
	localparam logic [1:0] MODE_HOLD   = 2'd2;	// out_ready low until done

	typedef struct packed {
		host_dma_pkg::dir_e   dir;
		host_dma_pkg::addr_t  start_addr;
		host_dma_pkg::count_t word_count;
		host_dma_pkg::word_t  seed;			// 0 keeps the data chain going
		logic [1:0]           mode;
	} row_t;

	logic                 okClk;
	logic                 rst_n;
	logic                 in_valid;
	host_dma_pkg::word_t  in_data;
	logic                 in_ready;
	logic                 out_ready;
	logic                 out_valid;
	host_dma_pkg::word_t  out_data;
	logic                 out_block_ready;
	logic                 xfer_valid;
	host_dma_pkg::xfer_t  xfer;
	logic                 xfer_ready;
	logic                 xfer_done;

	row_t                 rows [NUM_ROWS];
	host_dma_pkg::word_t  ref_mem [MEM_WORDS];	// expected memory contents
	host_dma_pkg::word_t  push_q [$];
	host_dma_pkg::word_t  rng;
	host_dma_pkg::count_t done_count;
	logic                 block_seen;
	int                   cycle_count;
	int                   timeout_cycles;

	`include "host_dma_checks.svh"

	host_dma_top #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.BLOCK_SIZE (BLOCK_SIZE),
		.HEADROOM   (HEADROOM),
		.BURST_LEN  (BURST_LEN),
		.MEM_WORDS  (MEM_WORDS)
	) uut (
		.okClk           (okClk),
		.rst_n           (rst_n),
		.in_valid        (in_valid),
		.in_data         (in_data),
		.in_ready        (in_ready),
		.out_ready       (out_ready),
		.out_valid       (out_valid),
		.out_data        (out_data),
		.out_block_ready (out_block_ready),
		.xfer_valid      (xfer_valid),
		.xfer            (xfer),
		.xfer_ready      (xfer_ready),
		.xfer_done       (xfer_done)
	);

	initial begin
		okClk = 1'b0;
		forever #2 okClk = ~okClk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count <= timeout_cycles) begin
			@(posedge okClk);
			cycle_count++;
		end
		$display("timeout: transfers did not finish within %0d cycles", timeout_cycles);
		$display("STATUS: FAIL");
		$fatal(1, "simulation timed out");
	end

	// every xfer_done cycle over the whole run, apart from the row loop
	initial begin
		forever begin
			@(posedge okClk);
			#1;
			if (xfer_done === 1'b1) begin
				done_count++;
			end
		end
	end

	// ----------------------------------------------------------
	// host side tasks, entered and left 1 ns after a rising edge
	// ----------------------------------------------------------

	task automatic load_words(input host_dma_pkg::addr_t addr, input host_dma_pkg::count_t n);
		push_q.delete();
		for (int i = 0; i < int'(n); i++) begin
			rng = xorshift32(rng);
			ref_mem[int'(addr) + i] = rng;
			push_q.push_back(rng);
		end
	endtask

	task automatic push_words();
		logic ready_now;
		while (push_q.size() > 0) begin
			in_valid  = 1'b1;
			in_data   = push_q[0];
			ready_now = in_ready;			// value seen at the coming edge
			@(posedge okClk);
			#1;
			if (ready_now) begin
				push_q.delete(0);
			end
		end
		in_valid = 1'b0;
	endtask

	task automatic fill_input(input host_dma_pkg::addr_t addr,
		output host_dma_pkg::count_t accepted);
		accepted = '0;
		while (in_ready) begin
			rng      = xorshift32(rng);
			in_valid = 1'b1;
			in_data  = rng;
			ref_mem[int'(addr) + int'(accepted)] = rng;
			@(posedge okClk);
			#1;
			accepted++;
		end
		in_valid = 1'b0;
	endtask

	task automatic send_xfer(input host_dma_pkg::dir_e xdir, input host_dma_pkg::addr_t addr,
		input host_dma_pkg::count_t n);
		logic ready_now;
		xfer_valid = 1'b1;
		xfer       = '{dir: xdir, start_addr: addr, word_count: n};
		ready_now  = 1'b0;
		while (!ready_now) begin
			ready_now = xfer_ready;
			@(posedge okClk);
			#1;
		end
		xfer_valid = 1'b0;
		check_flag("xfer_ready", 1'b0, xfer_ready);	// busy right after acceptance
	endtask

	task automatic wait_done();
		while (!xfer_done) begin
			check_flag("xfer_ready", 1'b0, xfer_ready);
			if (out_block_ready) begin
				block_seen = 1'b1;
			end
			@(posedge okClk);
			#1;
		end
		@(posedge okClk);
		#1;
		check_flag("xfer_done", 1'b0, xfer_done);	// single cycle pulse
		check_flag("xfer_ready", 1'b1, xfer_ready);
	endtask

	task automatic drain_words(input host_dma_pkg::addr_t addr, input host_dma_pkg::count_t n);
		int idx;
		idx       = 0;
		out_ready = 1'b1;
		while (idx < int'(n)) begin
			if (out_block_ready) begin
				block_seen = 1'b1;
			end
			if (out_valid) begin
				check_word("out_data", ref_mem[int'(addr) + idx], out_data);
				idx++;
			end
			@(posedge okClk);
			#1;
		end
		out_ready = 1'b0;
		check_flag("out_valid", 1'b0, out_valid);
	endtask

	// ----------------------------------------------------------
	// stimulus table and main loop
	// ----------------------------------------------------------

	initial begin
		row_t                 row;
		host_dma_pkg::count_t accepted;
		logic                 block_exp;
		int                   total;

		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_data    = '0;
		out_ready  = 1'b0;
		xfer_valid = 1'b0;
		xfer       = '0;
		done_count = '0;
		block_seen = 1'b0;

		rows[0] = '{host_dma_pkg::DIR_WRITE, 16'd0,   16'd24, 32'hb7d109bf, MODE_STREAM};
		rows[1] = '{host_dma_pkg::DIR_WRITE, 16'd64,  16'd13, 32'h0, MODE_STREAM};
		rows[2] = '{host_dma_pkg::DIR_READ,  16'd0,   16'd24, 32'h0, MODE_STREAM};
		rows[3] = '{host_dma_pkg::DIR_READ,  16'd64,  16'd13, 32'h0, MODE_STREAM};
		rows[4] = '{host_dma_pkg::DIR_READ,  16'd5,   16'd11, 32'h0, MODE_STREAM};
		rows[5] = '{host_dma_pkg::DIR_WRITE, 16'd128, FILL_WORDS, 32'h0, MODE_FILL};
		rows[6] = '{host_dma_pkg::DIR_READ,  16'd128, FILL_WORDS, 32'h0, MODE_STREAM};
		rows[7] = '{host_dma_pkg::DIR_WRITE, 16'd176, 16'd48, 32'h0, MODE_STREAM};
		rows[8] = '{host_dma_pkg::DIR_READ,  16'd176, 16'd48, 32'h0, MODE_HOLD};
		rows[9] = '{host_dma_pkg::DIR_READ,  16'd200, 16'd10, 32'h0, MODE_HOLD};

		total = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			total += int'(rows[r].word_count);
		end
		timeout_cycles = 20 * total + 2000;

		repeat (4) @(posedge okClk);
		#1;
		rst_n = 1'b1;

		check_flag("in_ready", 1'b1, in_ready);
		check_flag("xfer_ready", 1'b1, xfer_ready);
		check_flag("out_valid", 1'b0, out_valid);
		check_flag("out_block_ready", 1'b0, out_block_ready);
		check_flag("xfer_done", 1'b0, xfer_done);

		for (int r = 0; r < NUM_ROWS; r++) begin
			row = rows[r];
			if (row.seed != '0) begin
				rng = row.seed;
			end
			if (row.dir == host_dma_pkg::DIR_WRITE && row.mode == MODE_FILL) begin
				fill_input(row.start_addr, accepted);
				check_count("accepted words", row.word_count, accepted);
				send_xfer(row.dir, row.start_addr, row.word_count);
				wait_done();
				check_flag("in_ready", 1'b1, in_ready);	// throttle open again
			end else if (row.dir == host_dma_pkg::DIR_WRITE) begin
				load_words(row.start_addr, row.word_count);
				send_xfer(row.dir, row.start_addr, row.word_count);
				fork
					push_words();
					wait_done();
				join
			end else if (row.mode == MODE_HOLD) begin
				block_exp  = (row.word_count >= host_dma_pkg::count_t'(BLOCK_SIZE));
				block_seen = 1'b0;
				send_xfer(row.dir, row.start_addr, row.word_count);
				wait_done();
				check_flag("out_block_ready", block_exp, block_seen);	// nothing drained yet
				drain_words(row.start_addr, row.word_count);
				check_flag("out_block_ready", block_exp, block_seen);
				check_flag("out_block_ready", 1'b0, out_block_ready);
			end else begin
				send_xfer(row.dir, row.start_addr, row.word_count);
				fork
					drain_words(row.start_addr, row.word_count);
					wait_done();
				join
			end
		end

		check_count("xfer_done pulses", host_dma_pkg::count_t'(NUM_ROWS), done_count);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: compile.f
src/host_dma_pkg.sv
src/block_fifo.sv
src/burst_mem.sv
src/burst_dma.sv
src/host_dma_top.sv
verif/host_dma_tb.sv
+incdir+verif

// File: run.sh
#!/bin/sh
# build and run the host dma testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module host_dma_tb \
	-Mdir obj_dir \
	-f compile.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/Vhost_dma_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "simulation ended with status $sim_status"
	exit 1
fi

echo "simulation finished cleanly"
exit 0
